// ==== design/lsq_pkg.sv ====
`default_nettype none

package lsq_pkg;

  // Doubleword address, byte address without its three low bits
  localparam int WORD_ADDR_W = 29;
  localparam int DATA_W      = 64;

  typedef logic [WORD_ADDR_W-1:0] word_addr_t;
  typedef logic [DATA_W-1:0]      data_t;

  // Operation class at dispatch and retire
  typedef enum logic {
    MEM_LOAD  = 1'b0,
    MEM_STORE = 1'b1
  } mem_op_e;

  // Store execution payload, also the cache write
  typedef struct packed {
    word_addr_t addr;
    data_t      data;
  } mem_write_t;

  // Answer from the store queue search
  typedef struct packed {
    logic  hit;
    data_t data;
  } fwd_result_t;

  // Completed load
  typedef struct packed {
    data_t data;
    logic  forwarded;
  } load_result_t;

endpackage

`default_nettype wire

// ==== design/queue_ptrs.sv ====
`timescale 1ns/10ps
`default_nettype none

module queue_ptrs #(
  parameter int DEPTH = 8
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 push,
  input  logic                 pop,
  output logic [$clog2(DEPTH):0] head,
  output logic [$clog2(DEPTH):0] tail,
  output logic                 full,
  output logic [$clog2(DEPTH):0] count
);

  localparam int IDX_W = $clog2(DEPTH);

  assign count = tail - head;

  // Same slot, opposite lap
  assign full = (head[IDX_W-1:0] == tail[IDX_W-1:0]) && (head[IDX_W] != tail[IDX_W]);

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (push) begin
        tail <= tail + 1'b1;
      end
      if (pop) begin
        head <= head + 1'b1;
      end
    end
  end

  assert property (@(posedge clock) disable iff (reset) pop |-> count != '0)
    else $error("queue_ptrs: pop on empty queue");

  assert property (@(posedge clock) disable iff (reset) push |-> !full)
    else $error("queue_ptrs: push on full queue");

endmodule

`default_nettype wire

// ==== design/store_forward.sv ====
`timescale 1ns/10ps
`default_nettype none

module store_forward import lsq_pkg::*; #(
  parameter int DEPTH = 8
) (
  input  word_addr_t [DEPTH-1:0]   entry_addr,
  input  logic [DEPTH-1:0]         entry_done,
  input  logic [$clog2(DEPTH):0]   head,
  input  logic [$clog2(DEPTH):0]   bound,
  input  word_addr_t               addr,
  output logic                     hit,
  output logic [$clog2(DEPTH)-1:0] hit_idx
);

  localparam int IDX_W = $clog2(DEPTH);
  localparam int PTR_W = IDX_W + 1;

  logic [PTR_W-1:0] span;
  logic             in_range;
  logic [IDX_W-1:0] slot;

  // Stores older than the load, head up to bound
  assign span = bound - head;

  // Larger span means the recorded stores have already left the queue
  assign in_range = span <= PTR_W'(DEPTH);

  // Walk oldest to youngest so the last match wins
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    slot    = '0;
    for (int k = 0; k < DEPTH; k++) begin
      slot = head[IDX_W-1:0] + IDX_W'(k);
      if (in_range && (PTR_W'(k) < span) && entry_done[slot] &&
          (entry_addr[slot] == addr)) begin
        hit     = 1'b1;
        hit_idx = slot;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/store_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

module store_queue import lsq_pkg::*; #(
  parameter int DEPTH = 8
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     dispatch_push,
  input  logic                     exec_valid,
  input  logic [$clog2(DEPTH)-1:0] exec_idx,
  input  mem_write_t               exec,
  input  logic                     retire_pop,
  input  word_addr_t               fwd_addr,
  input  logic [$clog2(DEPTH):0]   fwd_bound,
  output logic                     full,
  output logic [$clog2(DEPTH):0]   tail,
  output fwd_result_t              fwd,
  output logic                     cache_wr_en,
  output mem_write_t               cache_wr
);

  localparam int IDX_W = $clog2(DEPTH);

  mem_write_t             entry [DEPTH];
  logic [DEPTH-1:0]       done;
  word_addr_t [DEPTH-1:0] entry_addr;
  logic [IDX_W:0]         head;
  logic [IDX_W-1:0]       head_idx;
  logic [IDX_W-1:0]       tail_idx;
  logic                   hit;
  logic [IDX_W-1:0]       hit_idx;

  assign head_idx = head[IDX_W-1:0];
  assign tail_idx = tail[IDX_W-1:0];

  queue_ptrs #(
    .DEPTH (DEPTH)
  ) u_ptrs (
    .clock (clock),
    .reset (reset),
    .push  (dispatch_push),
    .pop   (retire_pop),
    .head  (head),
    .tail  (tail),
    .full  (full),
    .count ()
  );

  // New entry waits for its execute
  always_ff @(posedge clock) begin
    if (reset) begin
      done <= '0;
    end else begin
      if (dispatch_push) begin
        done[tail_idx] <= 1'b0;
      end
      if (exec_valid) begin
        done[exec_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (exec_valid) begin
      entry[exec_idx] <= exec;
    end
  end

  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      entry_addr[i] = entry[i].addr;
    end
  end

  store_forward #(
    .DEPTH (DEPTH)
  ) u_fwd (
    .entry_addr (entry_addr),
    .entry_done (done),
    .head       (head),
    .bound      (fwd_bound),
    .addr       (fwd_addr),
    .hit        (hit),
    .hit_idx    (hit_idx)
  );

  always_comb begin
    fwd.hit  = hit;
    fwd.data = entry[hit_idx].data;
  end

  // Head store goes to the cache as it retires
  assign cache_wr_en = retire_pop;
  assign cache_wr    = entry[head_idx];

  assert property (@(posedge clock) disable iff (reset) retire_pop |-> done[head_idx])
    else $error("store_queue: retiring store was never executed");

endmodule

`default_nettype wire

// ==== design/load_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

module load_queue import lsq_pkg::*; #(
  parameter int DEPTH = 8
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     dispatch_push,
  input  logic [$clog2(DEPTH):0]   sq_tail,
  input  logic                     exec_valid,
  input  logic [$clog2(DEPTH)-1:0] exec_idx,
  input  word_addr_t               exec_addr,
  input  fwd_result_t              fwd,
  input  logic                     cache_rsp_valid,
  input  data_t                    cache_rsp_data,
  input  logic                     retire_pop,
  output logic                     full,
  output logic [$clog2(DEPTH):0]   tail,
  output word_addr_t               fwd_addr,
  output logic [$clog2(DEPTH):0]   fwd_bound,
  output logic                     cache_rd_en,
  output word_addr_t               cache_rd_addr,
  output logic                     done_valid,
  output logic [$clog2(DEPTH)-1:0] done_idx,
  output load_result_t             done
);

  localparam int IDX_W = $clog2(DEPTH);

  // Store tail seen by each load at dispatch
  logic [IDX_W:0]   bound [DEPTH];
  logic [IDX_W-1:0] tail_idx;
  logic             pending;
  logic [IDX_W-1:0] pend_idx;
  logic             fwd_take;
  logic             rsp_take;
  logic             miss;

  assign tail_idx = tail[IDX_W-1:0];

  queue_ptrs #(
    .DEPTH (DEPTH)
  ) u_ptrs (
    .clock (clock),
    .reset (reset),
    .push  (dispatch_push),
    .pop   (retire_pop),
    .head  (),
    .tail  (tail),
    .full  (full),
    .count ()
  );

  always_ff @(posedge clock) begin
    if (dispatch_push) begin
      bound[tail_idx] <= sq_tail;
    end
  end

  assign fwd_addr  = exec_addr;
  assign fwd_bound = bound[exec_idx];

  assign fwd_take = exec_valid && fwd.hit;
  assign miss     = exec_valid && !fwd.hit;
  assign rsp_take = cache_rsp_valid && pending;

  // Cache read goes out in the execute cycle
  assign cache_rd_en   = miss;
  assign cache_rd_addr = exec_addr;

  always_ff @(posedge clock) begin
    if (reset) begin
      done_valid <= 1'b0;
      pending    <= 1'b0;
    end else begin
      done_valid <= fwd_take || rsp_take;
      if (rsp_take) begin
        pending <= 1'b0;
      end
      if (miss) begin
        pending <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (miss) begin
      pend_idx <= exec_idx;
    end
    if (rsp_take) begin
      done_idx       <= pend_idx;
      done.data      <= cache_rsp_data;
      done.forwarded <= 1'b0;
    end else if (fwd_take) begin
      done_idx       <= exec_idx;
      done.data      <= fwd.data;
      done.forwarded <= 1'b1;
    end
  end

  // One outstanding cache read
  assert property (@(posedge clock) disable iff (reset) miss |-> !pending)
    else $error("load_queue: cache miss while a read is outstanding");

  // Single result port, a hit must not land on a response cycle
  assert property (@(posedge clock) disable iff (reset) !(rsp_take && fwd_take))
    else $error("load_queue: forward hit collides with cache response");

endmodule

`default_nettype wire

// ==== design/lsq_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module lsq_top import lsq_pkg::*; #(
  parameter int DEPTH = 8
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     dispatch_valid,
  input  mem_op_e                  dispatch_op,
  output logic                     dispatch_ready,
  output logic [$clog2(DEPTH)-1:0] dispatch_idx,
  input  logic                     store_exec_valid,
  input  logic [$clog2(DEPTH)-1:0] store_exec_idx,
  input  mem_write_t               store_exec,
  input  logic                     load_exec_valid,
  input  logic [$clog2(DEPTH)-1:0] load_exec_idx,
  input  word_addr_t               load_exec_addr,
  output logic                     cache_rd_en,
  output word_addr_t               cache_rd_addr,
  input  logic                     cache_rsp_valid,
  input  data_t                    cache_rsp_data,
  output logic                     load_done_valid,
  output logic [$clog2(DEPTH)-1:0] load_done_idx,
  output load_result_t             load_done,
  input  logic                     retire_valid,
  input  mem_op_e                  retire_op,
  output logic                     cache_wr_en,
  output mem_write_t               cache_wr
);

  localparam int IDX_W = $clog2(DEPTH);

  logic           sq_push;
  logic           lq_push;
  logic           sq_pop;
  logic           lq_pop;
  logic           sq_full;
  logic           lq_full;
  logic [IDX_W:0] sq_tail;
  logic [IDX_W:0] lq_tail;
  word_addr_t     fwd_addr;
  logic [IDX_W:0] fwd_bound;
  fwd_result_t    fwd;

  assign sq_push = dispatch_valid && (dispatch_op == MEM_STORE);
  assign lq_push = dispatch_valid && (dispatch_op == MEM_LOAD);
  assign sq_pop  = retire_valid && (retire_op == MEM_STORE);
  assign lq_pop  = retire_valid && (retire_op == MEM_LOAD);

  // Ready and index follow the queue being addressed
  assign dispatch_ready = (dispatch_op == MEM_STORE) ? !sq_full : !lq_full;
  assign dispatch_idx   = (dispatch_op == MEM_STORE) ? sq_tail[IDX_W-1:0] : lq_tail[IDX_W-1:0];

  store_queue #(
    .DEPTH (DEPTH)
  ) u_sq (
    .clock         (clock),
    .reset         (reset),
    .dispatch_push (sq_push),
    .exec_valid    (store_exec_valid),
    .exec_idx      (store_exec_idx),
    .exec          (store_exec),
    .retire_pop    (sq_pop),
    .fwd_addr      (fwd_addr),
    .fwd_bound     (fwd_bound),
    .full          (sq_full),
    .tail          (sq_tail),
    .fwd           (fwd),
    .cache_wr_en   (cache_wr_en),
    .cache_wr      (cache_wr)
  );

  load_queue #(
    .DEPTH (DEPTH)
  ) u_lq (
    .clock           (clock),
    .reset           (reset),
    .dispatch_push   (lq_push),
    .sq_tail         (sq_tail),
    .exec_valid      (load_exec_valid),
    .exec_idx        (load_exec_idx),
    .exec_addr       (load_exec_addr),
    .fwd             (fwd),
    .cache_rsp_valid (cache_rsp_valid),
    .cache_rsp_data  (cache_rsp_data),
    .retire_pop      (lq_pop),
    .full            (lq_full),
    .tail            (lq_tail),
    .fwd_addr        (fwd_addr),
    .fwd_bound       (fwd_bound),
    .cache_rd_en     (cache_rd_en),
    .cache_rd_addr   (cache_rd_addr),
    .done_valid      (load_done_valid),
    .done_idx        (load_done_idx),
    .done            (load_done)
  );

  assert property (@(posedge clock) disable iff (reset) dispatch_valid |-> dispatch_ready)
    else $error("lsq_top: dispatch into a full queue");

endmodule

`default_nettype wire

// ==== tests/lsq_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module lsq_tb import lsq_pkg::*; ();

  localparam int DEPTH = 8;
  localparam int IDX_W = $clog2(DEPTH);
  localparam int TIMEOUT_CYCLES = 3000;

  logic             clock;
  logic             reset;
  logic             dispatch_valid;
  mem_op_e          dispatch_op;
  logic             dispatch_ready;
  logic [IDX_W-1:0] dispatch_idx;
  logic             store_exec_valid;
  logic [IDX_W-1:0] store_exec_idx;
  mem_write_t       store_exec;
  logic             load_exec_valid;
  logic [IDX_W-1:0] load_exec_idx;
  word_addr_t       load_exec_addr;
  logic             cache_rd_en;
  word_addr_t       cache_rd_addr;
  logic             cache_rsp_valid = 1'b0;
  data_t            cache_rsp_data = '0;
  logic             load_done_valid;
  logic [IDX_W-1:0] load_done_idx;
  load_result_t     load_done;
  logic             retire_valid;
  mem_op_e          retire_op;
  logic             cache_wr_en;
  mem_write_t       cache_wr;

  // Cache model state
  integer     seed = 32'he3bd0374;
  data_t      cache_mem [word_addr_t];
  int         rd_wait = 0;
  word_addr_t rd_addr;

  // Expected queue state in program order
  mem_write_t sq_entry [DEPTH];
  int         sq_next = 0;
  int         lq_next = 0;
  int         sq_head = 0;
  int         cycle_count = 0;

  lsq_top #(
    .DEPTH (DEPTH)
  ) u_dut (
    .clock            (clock),
    .reset            (reset),
    .dispatch_valid   (dispatch_valid),
    .dispatch_op      (dispatch_op),
    .dispatch_ready   (dispatch_ready),
    .dispatch_idx     (dispatch_idx),
    .store_exec_valid (store_exec_valid),
    .store_exec_idx   (store_exec_idx),
    .store_exec       (store_exec),
    .load_exec_valid  (load_exec_valid),
    .load_exec_idx    (load_exec_idx),
    .load_exec_addr   (load_exec_addr),
    .cache_rd_en      (cache_rd_en),
    .cache_rd_addr    (cache_rd_addr),
    .cache_rsp_valid  (cache_rsp_valid),
    .cache_rsp_data   (cache_rsp_data),
    .load_done_valid  (load_done_valid),
    .load_done_idx    (load_done_idx),
    .load_done        (load_done),
    .retire_valid     (retire_valid),
    .retire_op        (retire_op),
    .cache_wr_en      (cache_wr_en),
    .cache_wr         (cache_wr)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Some tests failed");
      $fatal(1, "Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    end
  end

  // Unwritten words read back a pattern built from the whole address
  function automatic data_t fill_word(input word_addr_t addr);
    return {3'b101, addr, ~addr, 3'b011};
  endfunction

  function automatic data_t cache_read(input word_addr_t addr);
    return cache_mem.exists(addr) ? cache_mem[addr] : fill_word(addr);
  endfunction

  // Data cache model answering a read after 1 to 4 cycles
  always @(posedge clock) begin
    if (reset) begin
      cache_rsp_valid <= 1'b0;
      rd_wait = 0;
    end else begin
      cache_rsp_valid <= 1'b0;
      if (cache_wr_en) begin
        cache_mem[cache_wr.addr] = cache_wr.data;
      end
      if (cache_rd_en) begin
        rd_addr = cache_rd_addr;
        rd_wait = 1 + $unsigned($random(seed)) % 4;
      end
      if (rd_wait == 1) begin
        cache_rsp_valid <= 1'b1;
        cache_rsp_data  <= cache_read(rd_addr);
      end
      if (rd_wait > 0) begin
        rd_wait = rd_wait - 1;
      end
    end
  end

  task automatic check(input string name, input logic [127:0] expected,
                       input logic [127:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
      $display("Some tests failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic expect_ready(input string name, input mem_op_e op, input logic expected);
    @(posedge clock);
    dispatch_op <= op;
    @(negedge clock);
    check(name, expected, dispatch_ready);
  endtask

  task automatic dispatch(input string name, input mem_op_e op, output logic [IDX_W-1:0] idx);
    int expected;
    expected = (op == MEM_STORE) ? sq_next : lq_next;
    expect_ready({name, " ready"}, op, 1'b1);
    check({name, " dispatch index"}, expected, dispatch_idx);
    idx = dispatch_idx;
    @(posedge clock);
    dispatch_valid <= 1'b1;
    @(posedge clock);
    dispatch_valid <= 1'b0;
    if (op == MEM_STORE) begin
      sq_next = (sq_next + 1) % DEPTH;
    end else begin
      lq_next = (lq_next + 1) % DEPTH;
    end
  endtask

  task automatic exec_store(input logic [IDX_W-1:0] idx, input word_addr_t waddr,
                            input data_t wdata);
    @(posedge clock);
    store_exec_valid <= 1'b1;
    store_exec_idx   <= idx;
    store_exec       <= '{addr: waddr, data: wdata};
    @(posedge clock);
    store_exec_valid <= 1'b0;
    sq_entry[idx] = '{addr: waddr, data: wdata};
  endtask

  task automatic retire(input string name, input mem_op_e op);
    @(posedge clock);
    retire_valid <= 1'b1;
    retire_op    <= op;
    @(negedge clock);
    check({name, " cache write enable"}, op == MEM_STORE, cache_wr_en);
    if (op == MEM_STORE) begin
      check({name, " cache write address"}, sq_entry[sq_head].addr, cache_wr.addr);
      check({name, " cache write data"}, sq_entry[sq_head].data, cache_wr.data);
      sq_head = (sq_head + 1) % DEPTH;
    end
    @(posedge clock);
    retire_valid <= 1'b0;
  endtask

  task automatic run_load(input string name, input logic [IDX_W-1:0] idx, input word_addr_t addr,
                          input logic forwarded, input data_t expected);
    @(posedge clock);
    load_exec_valid <= 1'b1;
    load_exec_idx   <= idx;
    load_exec_addr  <= addr;
    @(negedge clock);
    check({name, " cache read"}, !forwarded, cache_rd_en);
    if (!forwarded) begin
      check({name, " cache read address"}, addr, cache_rd_addr);
    end
    @(posedge clock);
    load_exec_valid <= 1'b0;
    @(negedge clock);
    if (!forwarded) begin
      // Result only after the response
      while (!cache_rsp_valid) begin
        check({name, " early result"}, 1'b0, load_done_valid);
        @(negedge clock);
      end
      check({name, " early result"}, 1'b0, load_done_valid);
      @(negedge clock);
    end
    check({name, " done valid"}, 1'b1, load_done_valid);
    check({name, " done index"}, idx, load_done_idx);
    check({name, " done data"}, expected, load_done.data);
    check({name, " forwarded flag"}, forwarded, load_done.forwarded);
  endtask

  task automatic reset_state();
    expect_ready("reset_state store ready", MEM_STORE, 1'b1);
    expect_ready("reset_state load ready", MEM_LOAD, 1'b1);
    repeat (4) begin
      @(negedge clock);
      check("reset_state load_done_valid", 1'b0, load_done_valid);
      check("reset_state cache_rd_en", 1'b0, cache_rd_en);
      check("reset_state cache_wr_en", 1'b0, cache_wr_en);
    end
  endtask

  task automatic fill_store_queue();
    logic [IDX_W-1:0] idx;
    for (int i = 0; i < DEPTH; i++) begin
      dispatch("fill_store_queue", MEM_STORE, idx);
    end
    expect_ready("fill_store_queue store ready", MEM_STORE, 1'b0);
    expect_ready("fill_store_queue load ready", MEM_LOAD, 1'b1);
  endtask

  task automatic retire_in_order();
    int               order [DEPTH] = '{5, 2, 7, 0, 3, 6, 1, 4};
    logic [IDX_W-1:0] idx;
    for (int i = 0; i < DEPTH; i++) begin
      exec_store(order[i], 29'h0010000 + order[i], 64'hc0de_0000_0000_0000 + order[i] * 64'h1_0001);
    end
    for (int i = 0; i < DEPTH; i++) begin
      retire("retire_in_order", MEM_STORE);
    end
    dispatch("retire_in_order", MEM_STORE, idx);
    exec_store(idx, 29'h0020000, 64'h0123_4567_89ab_cdef);
    retire("retire_in_order", MEM_STORE);
  endtask

  task automatic forward_youngest();
    logic [IDX_W-1:0] s_old;
    logic [IDX_W-1:0] s_young;
    logic [IDX_W-1:0] ld;
    dispatch("forward_youngest", MEM_STORE, s_old);
    dispatch("forward_youngest", MEM_STORE, s_young);
    // Older store executes last and must still lose
    exec_store(s_young, 29'h00abc, 64'h1111_2222_3333_4444);
    exec_store(s_old, 29'h00abc, 64'h9999_8888_7777_6666);
    dispatch("forward_youngest", MEM_LOAD, ld);
    run_load("forward_youngest", ld, 29'h00abc, 1'b1, 64'h1111_2222_3333_4444);
    retire("forward_youngest", MEM_STORE);
    retire("forward_youngest", MEM_STORE);
    retire("forward_youngest", MEM_LOAD);
  endtask

  task automatic forward_ignores_mismatch();
    logic [IDX_W-1:0] st;
    logic [IDX_W-1:0] ld;
    dispatch("forward_ignores_younger", MEM_LOAD, ld);
    dispatch("forward_ignores_younger", MEM_STORE, st);
    exec_store(st, 29'h00def, 64'hdead_beef_0000_0001);
    run_load("forward_ignores_younger", ld, 29'h00def, 1'b0, fill_word(29'h00def));
    retire("forward_ignores_younger", MEM_LOAD);
    retire("forward_ignores_younger", MEM_STORE);
    dispatch("forward_ignores_address", MEM_STORE, st);
    exec_store(st, 29'h00111, 64'hdead_beef_0000_0002);
    dispatch("forward_ignores_address", MEM_LOAD, ld);
    run_load("forward_ignores_address", ld, 29'h00222, 1'b0, fill_word(29'h00222));
    retire("forward_ignores_address", MEM_STORE);
    retire("forward_ignores_address", MEM_LOAD);
  endtask

  task automatic forward_ignores_retired();
    logic [IDX_W-1:0] st;
    logic [IDX_W-1:0] ld;
    dispatch("forward_ignores_retired", MEM_STORE, st);
    exec_store(st, 29'h00333, 64'h5a5a_a5a5_0f0f_f0f0);
    dispatch("forward_ignores_retired", MEM_LOAD, ld);
    retire("forward_ignores_retired", MEM_STORE);
    run_load("forward_ignores_retired", ld, 29'h00333, 1'b0, 64'h5a5a_a5a5_0f0f_f0f0);
    retire("forward_ignores_retired", MEM_LOAD);
  endtask

  initial begin
    reset            <= 1'b1;
    dispatch_valid   <= 1'b0;
    dispatch_op      <= MEM_LOAD;
    store_exec_valid <= 1'b0;
    store_exec_idx   <= '0;
    store_exec       <= '0;
    load_exec_valid  <= 1'b0;
    load_exec_idx    <= '0;
    load_exec_addr   <= '0;
    retire_valid     <= 1'b0;
    retire_op        <= MEM_LOAD;
    repeat (10) @(posedge clock);
    reset <= 1'b0;
    reset_state();
    fill_store_queue();
    retire_in_order();
    forward_youngest();
    forward_ignores_mismatch();
    forward_ignores_retired();
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
design/lsq_pkg.sv
design/queue_ptrs.sv
design/store_forward.sv
design/store_queue.sv
design/load_queue.sv
design/lsq_top.sv
tests/lsq_tb.sv
